/* design/fifoCompare.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// equivalence watcher for the two FIFOs
// flags any disagreement one cycle late and holds it until reset
module fifoCompare
    import fifoPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  fifoData_t srData,
    input  fifoData_t rbData,
    input  logic      srFull,
    input  logic      srEmpty,
    input  logic      rbFull,
    input  logic      rbEmpty,
    output logic      mismatch
);

    logic flagDiff;
    logic dataDiff;
    logic disagree;

    // either flag out of step
    assign flagDiff = (srFull != rbFull) || (srEmpty != rbEmpty);

    // data only counts when both sides actually hold something
    assign dataDiff = !srEmpty && !rbEmpty && (srData != rbData);

    assign disagree = flagDiff || dataDiff;

    // sticky flag
    // once set it ignores later agreement, only rstN clears it
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mismatch <= 1'b0;
        end else if (disagree) begin
            mismatch <= 1'b1;
        end
    end

endmodule

/* design/fifoPair.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// top level
// one stimulus into two FIFO styles, shift-register side exported,
// comparator reports whether the pair ever diverged
module fifoPair
    import fifoPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  fifoData_t dataIn,
    input  logic      push,
    input  logic      pop,
    output fifoData_t dataOut,
    output logic      full,
    output logic      empty,
    output logic      mismatch
);

    // shift-register side
    fifoData_t srData;
    logic      srFull;
    logic      srEmpty;
    // ring-buffer side
    fifoData_t rbData;
    logic      rbFull;
    logic      rbEmpty;

    srFifo u_srFifo (
        .clock   (clock),
        .rstN    (rstN),
        .dataIn  (dataIn),
        .push    (push),
        .pop     (pop),
        .dataOut (srData),
        .full    (srFull),
        .empty   (srEmpty)
    );

    rbFifo u_rbFifo (
        .clock   (clock),
        .rstN    (rstN),
        .dataIn  (dataIn),
        .push    (push),
        .pop     (pop),
        .dataOut (rbData),
        .full    (rbFull),
        .empty   (rbEmpty)
    );

    fifoCompare u_fifoCompare (
        .clock    (clock),
        .rstN     (rstN),
        .srData   (srData),
        .rbData   (rbData),
        .srFull   (srFull),
        .srEmpty  (srEmpty),
        .rbFull   (rbFull),
        .rbEmpty  (rbEmpty),
        .mismatch (mismatch)
    );

    // outside world sees the shift-register FIFO
    assign dataOut = srData;
    assign full    = srFull;
    assign empty   = srEmpty;

endmodule

/* design/fifoPkg.sv */
`include "fifo_config.svh"

package fifoPkg;

    // one queued word
    typedef logic [`FIFO_DATA_WIDTH-1:0] fifoData_t;
    // entry index for tail, write and read pointers
    typedef logic [`FIFO_ADDR_WIDTH-1:0] fifoAddr_t;
    // occupancy 0..FIFO_DEPTH, one extra bit so a full queue fits
    typedef logic [`FIFO_ADDR_WIDTH:0] fifoCount_t;

endpackage

/* design/fifo_config.svh */
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// width of one queued word
`define FIFO_DATA_WIDTH 4
// number of entries, must equal 2 ** FIFO_ADDR_WIDTH
`define FIFO_DEPTH 16
// width of an entry index
`define FIFO_ADDR_WIDTH 4

`endif

/* design/rbFifo.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// ring-buffer FIFO
// words stay where they were written, pointers chase each other
// around the array and a separate count tells full from empty
module rbFifo
    import fifoPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  fifoData_t dataIn,
    input  logic      push,
    input  logic      pop,
    output fifoData_t dataOut,
    output logic      full,
    output logic      empty
);

    // storage, no reset on payload
    fifoData_t  mem [`FIFO_DEPTH];
    // next slot to write
    fifoAddr_t  wrPtr;
    // slot holding the oldest word
    fifoAddr_t  rdPtr;
    // number of queued words
    fifoCount_t count;
    logic       pushOk;
    logic       popOk;

    // same acceptance rules as the shift-register side
    assign pushOk = push && !full;
    assign popOk  = pop && !push && !empty;

    // write port
    always_ff @(posedge clock) begin
        if (pushOk) begin
            mem[wrPtr] <= dataIn;
        end
    end

    // write pointer
    // depth is a power of two, so wrap comes from the natural overflow
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
        end else if (pushOk) begin
            wrPtr <= wrPtr + fifoAddr_t'(1);
        end
    end

    // read pointer
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
        end else if (popOk) begin
            rdPtr <= rdPtr + fifoAddr_t'(1);
        end
    end

    // occupancy
    // push and pop never both accepted, so one step either way
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (pushOk) begin
            count <= count + fifoCount_t'(1);
        end else if (popOk) begin
            count <= count - fifoCount_t'(1);
        end
    end

    // flags straight from the count
    assign empty = (count == '0);
    assign full  = (count == fifoCount_t'(`FIFO_DEPTH));

    // oldest word, held at 0 while empty to match the other side
    assign dataOut = empty ? '0 : mem[rdPtr];

endmodule

/* design/srFifo.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// shift-register FIFO
// new words always enter at position 0 and the rest move up by one,
// so the oldest word sits at the highest occupied index (the tail)
module srFifo
    import fifoPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  fifoData_t dataIn,
    input  logic      push,
    input  logic      pop,
    output fifoData_t dataOut,
    output logic      full,
    output logic      empty
);

    // shift array, index 0 is the newest word
    fifoData_t mem [`FIFO_DEPTH];
    // index of the oldest word, only meaningful when not empty
    fifoAddr_t tail;
    logic      emptyQ;
    logic      pushOk;
    logic      popOk;

    // push wins; a pop alongside any push is dropped, even on a full queue
    assign pushOk = push && !full;
    assign popOk  = pop && !push && !emptyQ;

    // payload shift on every accepted push
    always_ff @(posedge clock) begin
        if (pushOk) begin
            for (int i = `FIFO_DEPTH - 1; i > 0; i--) begin
                mem[i] <= mem[i-1];
            end
            mem[0] <= dataIn;
        end
    end

    // tail and empty tracking
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            tail   <= '0;
            emptyQ <= 1'b1;
        end else if (pushOk) begin
            // first word lands at 0 with tail already there
            if (!emptyQ) begin
                tail <= tail + fifoAddr_t'(1);
            end
            emptyQ <= 1'b0;
        end else if (popOk) begin
            // last word leaves, tail stays at 0
            if (tail == '0) begin
                emptyQ <= 1'b1;
            end else begin
                tail <= tail - fifoAddr_t'(1);
            end
        end
    end

    // tail at the top slot means every entry is in use
    assign full  = (tail == fifoAddr_t'(`FIFO_DEPTH - 1));
    assign empty = emptyQ;

    // oldest word, forced to 0 while nothing is queued
    assign dataOut = emptyQ ? '0 : mem[tail];

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the FIFO pair testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
    -f src.f --top-module fifoPairTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VfifoPairTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# result comes from the testbench's own verdict line
if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

/* src.f */
+incdir+design
design/fifoPkg.sv
design/srFifo.sv
design/rbFifo.sv
design/fifoCompare.sv
design/fifoPair.sv
test/fifoPairChecker.sv
test/fifoPairTb.sv

/* test/fifoPairChecker.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// watches the FIFO pair ports and compares them against a reference queue
module fifoPairChecker
    import fifoPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  logic      push,
    input  logic      pop,
    input  fifoData_t dataIn,
    input  fifoData_t dataOut,
    input  logic      full,
    input  logic      empty,
    input  logic      mismatch,
    input  logic      done,
    output int        errorCount
);

    // model queue with the oldest word at the front
    fifoData_t refQueue [$];
    // expected port values for the current cycle
    logic      expEmpty = 1'b1;
    logic      expFull = 1'b0;
    fifoData_t expData = '0;
    int        errors = 0;
    int        checkCount = 0;

    assign errorCount = errors;

    // applies one cycle of push and pop to the model
    // returns {empty, full, oldest word} as seen after the edge
    function automatic logic [`FIFO_DATA_WIDTH+1:0] modelStep(input logic doPush,
                                                             input logic doPop,
                                                             input fifoData_t word);
        fifoData_t  oldest;
        fifoCount_t occupancy;
        if (doPush && refQueue.size() < `FIFO_DEPTH) begin
            refQueue.push_back(word);
        end else if (doPop && !doPush && refQueue.size() > 0) begin
            // pop only counts when no push is present at all
            void'(refQueue.pop_front());
        end
        occupancy = fifoCount_t'(refQueue.size());
        oldest = (occupancy != '0) ? refQueue[0] : '0;
        return {occupancy == '0, occupancy == fifoCount_t'(`FIFO_DEPTH), oldest};
    endfunction

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkData(input fifoData_t got, input fifoData_t exp);
        checkCount++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: dataOut is 0x%h, expected 0x%h", $time, got, exp);
        end
    endtask

    // outputs are read before this edge's register updates land
    always @(posedge clock) begin
        if (!rstN) begin
            // reset clears the model and the first edge after release checks it
            refQueue.delete();
            expEmpty = 1'b1;
            expFull  = 1'b0;
            expData  = '0;
        end else begin
            checkFlag("empty", empty, expEmpty);
            checkFlag("full", full, expFull);
            checkFlag("mismatch", mismatch, 1'b0);
            // word has no meaning on an empty queue
            if (!expEmpty) begin
                checkData(dataOut, expData);
            end
            {expEmpty, expFull, expData} = modelStep(push, pop, dataIn);
        end
    end

    // closing summary
    always @(posedge done) begin
        $display("checker: %0d checks, %0d errors", checkCount, errors);
    end

endmodule

/* test/fifoPairTb.sv */
`timescale 1ns/10ps

`include "fifo_config.svh"

// testbench top for the FIFO equivalence pair
module fifoPairTb
    import fifoPkg::*;
();

    localparam int RANDOM_CYCLES = 600;
    // generous bound on the directed phases
    localparam int DIRECTED_CYCLES = 200;
    localparam int TIMEOUT_NS = (RANDOM_CYCLES + DIRECTED_CYCLES) * 4 + 400;

    logic      clock;
    logic      rstN;
    fifoData_t dataIn;
    logic      push;
    logic      pop;
    fifoData_t dataOut;
    logic      full;
    logic      empty;
    logic      mismatch;
    logic      done;
    int        errorCount;
    integer    seed = 32'h42f0;

    fifoPair u_fifoPair (
        .clock    (clock),
        .rstN     (rstN),
        .dataIn   (dataIn),
        .push     (push),
        .pop      (pop),
        .dataOut  (dataOut),
        .full     (full),
        .empty    (empty),
        .mismatch (mismatch)
    );

    fifoPairChecker u_checker (
        .clock      (clock),
        .rstN       (rstN),
        .push       (push),
        .pop        (pop),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .full       (full),
        .empty      (empty),
        .mismatch   (mismatch),
        .done       (done),
        .errorCount (errorCount)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // two cycles of reset while push and pop keep their values
    task automatic resetDut();
        @(negedge clock);
        rstN = 1'b0;
        repeat (2) @(negedge clock);
        rstN = 1'b1;
    endtask

    // one cycle of stimulus set up on the falling edge
    task automatic driveOp(input logic doPush, input logic doPop, input fifoData_t word);
        @(negedge clock);
        push   = doPush;
        pop    = doPop;
        dataIn = word;
    endtask

    // push counting words until the DUT reports full
    task automatic fillQueue(input fifoData_t firstWord);
        fifoData_t word;
        word = firstWord;
        @(negedge clock);
        while (!full) begin
            push   = 1'b1;
            pop    = 1'b0;
            dataIn = word;
            word   = word + fifoData_t'(1);
            @(negedge clock);
        end
        push = 1'b0;
    endtask

    // pop until the DUT reports empty
    task automatic drainQueue();
        @(negedge clock);
        while (!empty) begin
            push = 1'b0;
            pop  = 1'b1;
            @(negedge clock);
        end
        pop = 1'b0;
    endtask

    // alternating push-heavy and pop-heavy stretches of 64 cycles
    task automatic randomTraffic(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            r = $random(seed);
            if ((i / 64) % 2 == 0) begin
                driveOp(r[1:0] != 2'b00, r[2], r[8 +: `FIFO_DATA_WIDTH]);
            end else begin
                driveOp(r[1:0] == 2'b00, r[3:2] != 2'b00, r[8 +: `FIFO_DATA_WIDTH]);
            end
        end
    endtask

    initial begin
        rstN   = 1'b0;
        push   = 1'b0;
        pop    = 1'b0;
        dataIn = '0;
        done   = 1'b0;
        repeat (2) @(negedge clock);
        rstN = 1'b1;
        // reset state checked over a few idle cycles
        repeat (3) driveOp(1'b0, 1'b0, '0);

        // fill and push once too often before draining in order
        fillQueue(fifoData_t'(1));
        driveOp(1'b1, 1'b0, fifoData_t'(9));
        drainQueue();

        // pops on empty followed by a single word round trip
        repeat (3) driveOp(1'b0, 1'b1, '0);
        driveOp(1'b1, 1'b0, fifoData_t'(5));
        driveOp(1'b0, 1'b1, '0);
        driveOp(1'b0, 1'b0, '0);

        // push together with pop on a partly filled and then a full queue
        for (int i = 0; i < 4; i++) begin
            driveOp(1'b1, 1'b0, fifoData_t'(i + 2));
        end
        for (int i = 0; i < 4; i++) begin
            driveOp(1'b1, 1'b1, fifoData_t'(i + 8));
        end
        fillQueue(fifoData_t'(3));
        repeat (2) driveOp(1'b1, 1'b1, fifoData_t'(7));
        drainQueue();

        randomTraffic(RANDOM_CYCLES);

        // reset in the middle of traffic
        randomTraffic(20);
        // enough pushes to reach full whatever the occupancy was
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            driveOp(1'b1, 1'b0, fifoData_t'(i + 6));
        end
        resetDut();
        randomTraffic(30);
        drainQueue();

        repeat (2) driveOp(1'b0, 1'b0, '0);
        done = 1'b1;
        #1;
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stimulus did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule
